// ==== sources.f ====
+incdir+include
hw/cluster_pkg.sv
hw/cluster_periph_regs.sv
hw/hart_wakeup_ctrl.sv
hw/cluster_ctrl_top.sv
bench/cluster_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cluster_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/cluster_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random stimulus from seed 81 checked against a cycle model
// DUT outputs are sampled on the falling clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cluster_consts.svh"

module cluster_tb
  import cluster_pkg::*;
();

  localparam int CLK_HALF = 4;
  localparam int TIMEOUT  = 50;

  logic         clk;
  logic         arst_n;
  narrow_req_t  req;
  narrow_resp_t resp;
  hart_mask_t   msip;
  boot_req_t    boot;
  hart_mask_t   running;

  // Cycle model state
  addr_t        m_scratch;
  hart_mask_t   m_pending;
  wake_state_e  m_state [`CL_NR_HARTS];
  logic         m_resp_valid;
  data_t        m_resp_rdata;

  string        cur_test;
  logic         check_en;
  int           test_errs;
  int           total_errs;
  int           tests_run;

  cluster_ctrl_top cluster_ctrl_top_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .narrow_req_i  (req),
    .narrow_resp_o (resp),
    .msip_i        (msip),
    .boot_o        (boot),
    .running_o     (running)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Hard limit on simulated time
  initial begin
    #(40000 * CLK_HALF);
    $display("simulation time limit reached before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  function automatic hart_mask_t model_running();
    hart_mask_t m;
    m = '0;
    for (int h = 0; h < `CL_NR_HARTS; h++) begin
      m[h] = (m_state[h] == WAKE_RUN);
    end
    return m;
  endfunction

  function automatic boot_req_t model_boot();
    boot_req_t b;
    b = '0;
    for (int h = 0; h < `CL_NR_HARTS; h++) begin
      b.hart_mask[h] = (m_state[h] == WAKE_BOOT);
    end
    if (b.hart_mask != '0) begin
      b.entry = m_scratch;
    end
    return b;
  endfunction

  function automatic data_t model_read(input addr_t a);
    case (a)
      `CL_REG_SCRATCH0:                    return data_t'(m_scratch);
      `CL_REG_CLINT_SET, `CL_REG_CLINT_CLR: return data_t'(m_pending);
      `CL_REG_STATUS:                      return data_t'({m_pending, model_running()});
      default:                             return '0;
    endcase
  endfunction

  // Model sees the same pre-edge inputs as the DUT
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_scratch    <= '0;
      m_pending    <= '0;
      m_resp_valid <= 1'b0;
      m_resp_rdata <= '0;
      for (int h = 0; h < `CL_NR_HARTS; h++) m_state[h] <= WAKE_SLEEP;
    end else begin
      m_resp_valid <= req.valid;
      m_resp_rdata <= (req.valid && !req.write) ? model_read(req.addr) : '0;
      for (int h = 0; h < `CL_NR_HARTS; h++) begin
        case (m_state[h])
          WAKE_SLEEP: if (msip[h] || m_pending[h]) m_state[h] <= WAKE_BOOT;
          WAKE_BOOT:  m_state[h] <= WAKE_RUN;
          default:    if (!msip[h] && !m_pending[h]) m_state[h] <= WAKE_SLEEP;
        endcase
      end
      if (req.valid && req.write) begin
        case (req.addr)
          `CL_REG_SCRATCH0:  m_scratch <= req.wdata;
          `CL_REG_CLINT_SET: m_pending <= m_pending | req.wdata[`CL_NR_HARTS-1:0];
          `CL_REG_CLINT_CLR: m_pending <= m_pending & ~req.wdata[`CL_NR_HARTS-1:0];
          default: ;
        endcase
      end
    end
  end

  task automatic report_failure(input string msg);
    $display("[%s] %s", cur_test, msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_mask(input string what, input hart_mask_t exp, input hart_mask_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_boot(input string what, input boot_req_t exp, input boot_req_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected mask %b entry %h, actual mask %b entry %h",
               cur_test, what, exp.hart_mask, exp.entry, act.hart_mask, act.entry);
      test_errs++;
      total_errs++;
    end
  endtask

  // Every cycle compare against the model
  always @(negedge clk) begin
    boot_req_t exp_b;
    if (check_en) begin
      check_data("resp valid", data_t'(m_resp_valid), data_t'(resp.valid));
      if (m_resp_valid) check_data("resp data", m_resp_rdata, resp.rdata);
      check_mask("running", model_running(), running);
      exp_b = model_boot();
      // Entry only carries meaning while a hart boots
      if (exp_b.hart_mask != '0) begin
        check_boot("boot", exp_b, boot);
      end else begin
        check_mask("boot mask", '0, boot.hart_mask);
      end
    end
  end

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("test %s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "failed",
             test_errs);
  endtask

  task automatic drive(input logic v, input logic w, input addr_t a, input data_t d);
    @(posedge clk);
    req <= '{valid: v, write: w, addr: a, wdata: d};
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, '0, '0);
  endtask

  task automatic write_reg(input addr_t a, input data_t d);
    drive(1'b1, 1'b1, a, d);
  endtask

  task automatic read_reg(input addr_t a, output data_t rd);
    int n;
    drive(1'b1, 1'b0, a, '0);
    idle();
    n = 0;
    @(negedge clk);
    while (!resp.valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!resp.valid) report_failure("timed out waiting for a read response");
    check_data("read latency", '0, data_t'(n));
    rd = resp.rdata;
  endtask

  // Counts falling edges until a boot pulse shows
  task automatic wait_boot(output int n);
    n = 1;
    @(negedge clk);
    while (boot.hart_mask == '0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (boot.hart_mask == '0) report_failure("timed out waiting for a boot pulse");
  endtask

  task automatic wait_run_mask(input hart_mask_t m, input hart_mask_t want);
    int n;
    n = 0;
    @(negedge clk);
    while ((running & m) != want && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if ((running & m) != want) report_failure("timed out waiting for the running mask");
  endtask

  initial begin
    int         rnd;
    int         n;
    int         h;
    data_t      rd;
    addr_t      entry;
    hart_mask_t mask;
    boot_req_t  exp_boot;
    arst_n     = 1'b0;
    req        = '0;
    msip       = '0;
    check_en   = 1'b0;
    test_errs  = 0;
    total_errs = 0;
    tests_run  = 0;
    cur_test   = "reset";
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    rnd = $urandom(81);
    @(posedge clk);
    check_en = 1'b1;

    begin_test("reset");
    @(negedge clk);
    check_mask("running", '0, running);
    check_mask("boot", '0, boot.hart_mask);
    read_reg(`CL_REG_STATUS, rd);
    check_data("status", '0, rd);
    finish_test();

    begin_test("scratch");
    for (int i = 0; i < 8; i++) begin
      entry = addr_t'($urandom);
      write_reg(`CL_REG_SCRATCH0, entry);
      read_reg(`CL_REG_SCRATCH0, rd);
      check_data("readback", data_t'(entry), rd);
    end
    // Back-to-back reads and writes checked by the model
    for (int i = 0; i < 24; i++) begin
      drive(1'b1, 1'($urandom), `CL_REG_SCRATCH0, data_t'($urandom));
    end
    idle();
    finish_test();

    begin_test("boot");
    h     = $urandom % `CL_NR_HARTS;
    mask  = hart_mask_t'(1) << h;
    entry = addr_t'($urandom);
    write_reg(`CL_REG_SCRATCH0, entry);
    write_reg(`CL_REG_CLINT_SET, data_t'(mask));
    idle();
    wait_boot(n);
    check_data("cycles to boot", 32'd2, data_t'(n));
    exp_boot.hart_mask = mask;
    exp_boot.entry     = entry;
    check_boot("boot pulse", exp_boot, boot);
    @(negedge clk);
    check_mask("pulse width", '0, boot.hart_mask);
    check_mask("running", mask, running);
    read_reg(`CL_REG_STATUS, rd);
    check_data("status", data_t'({mask, mask}), rd);
    write_reg(`CL_REG_CLINT_CLR, '1);
    idle();
    wait_run_mask('1, '0);
    finish_test();

    begin_test("clint mix");
    for (int i = 0; i < 80; i++) begin
      drive(1'b1, 1'($urandom), addr_t'(($urandom % 4) * 4), data_t'($urandom));
      msip <= hart_mask_t'($urandom & $urandom);
    end
    idle();
    msip <= '0;
    write_reg(`CL_REG_CLINT_CLR, '1);
    idle();
    wait_run_mask('1, '0);
    // A cleared bit must not sleep a hart that msip still holds awake
    h    = $urandom % `CL_NR_HARTS;
    mask = hart_mask_t'(1) << h;
    write_reg(`CL_REG_CLINT_SET, data_t'(mask));
    msip <= mask;
    idle();
    wait_run_mask(mask, mask);
    write_reg(`CL_REG_CLINT_CLR, data_t'(mask));
    idle();
    repeat (3) @(negedge clk);
    check_mask("held by msip", mask, running & mask);
    @(posedge clk);
    msip <= '0;
    wait_run_mask(mask, '0);
    finish_test();

    begin_test("multi boot");
    mask = hart_mask_t'($urandom);
    if ($countones(mask) < 2) mask = mask | hart_mask_t'(5);
    entry = addr_t'($urandom);
    write_reg(`CL_REG_SCRATCH0, entry);
    write_reg(`CL_REG_CLINT_SET, data_t'(mask));
    idle();
    wait_boot(n);
    exp_boot.hart_mask = mask;
    exp_boot.entry     = entry;
    check_boot("shared pulse", exp_boot, boot);
    // Offsets with a bit at or above 4 set hit no register
    write_reg(addr_t'($urandom) | addr_t'(32'h10), data_t'($urandom));
    idle();
    read_reg(addr_t'($urandom) | addr_t'(32'h10), rd);
    check_data("unmapped read", '0, rd);
    read_reg(`CL_REG_SCRATCH0, rd);
    check_data("scratch kept", data_t'(entry), rd);
    read_reg(`CL_REG_CLINT_SET, rd);
    check_data("pending kept", data_t'(mask), rd);
    finish_test();

    $display("tests run: %0d, errors: %0d", tests_run, total_errs);
    if (total_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hw/cluster_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host writes to CLINT_SET boot a hart two cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cluster_consts.svh"

module cluster_ctrl_top
  import cluster_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  narrow_req_t  narrow_req_i,
  output narrow_resp_t narrow_resp_o,
  input  hart_mask_t   msip_i,
  output boot_req_t    boot_o,
  output hart_mask_t   running_o
);

  hart_mask_t clint_pending;
  addr_t      entry_point;
  hart_mask_t hart_running;

  // Register port facing the host
  cluster_periph_regs i_periph_regs (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .narrow_req_i    (narrow_req_i),
    .narrow_resp_o   (narrow_resp_o),
    .hart_running_i  (hart_running),
    .clint_pending_o (clint_pending),
    .entry_point_o   (entry_point)
  );

  // Per-hart sleep and boot control
  hart_wakeup_ctrl i_wakeup_ctrl (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .msip_i          (msip_i),
    .clint_pending_i (clint_pending),
    .entry_point_i   (entry_point),
    .boot_o          (boot_o),
    .running_o       (hart_running)
  );

  assign running_o = hart_running;

endmodule

// ==== hw/hart_wakeup_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// msip_i is a level, sampled every edge
// Harts booting together share one entry value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cluster_consts.svh"

module hart_wakeup_ctrl
  import cluster_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  hart_mask_t msip_i,
  input  hart_mask_t clint_pending_i,
  input  addr_t      entry_point_i,
  output boot_req_t  boot_o,
  output hart_mask_t running_o
);

  hart_mask_t boot_mask;
  hart_mask_t run_mask;

  for (genvar h = 0; h < `CL_NR_HARTS; h++) begin : gen_hart
    wake_state_e state_q;
    wake_state_e state_d;
    logic        wake;

    // Software or cluster-local interrupt wakes the hart
    assign wake = msip_i[h] | clint_pending_i[h];

    always_comb begin
      state_d = state_q;
      unique case (state_q)
        WAKE_SLEEP: begin
          if (wake) begin
            state_d = WAKE_BOOT;
          end
        end
        // Boot lasts exactly one cycle
        WAKE_BOOT: begin
          state_d = WAKE_RUN;
        end
        WAKE_RUN: begin
          if (!wake) begin
            state_d = WAKE_SLEEP;
          end
        end
        default: begin
          state_d = WAKE_SLEEP;
        end
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q <= WAKE_SLEEP;
      end else begin
        state_q <= state_d;
      end
    end

    assign boot_mask[h] = (state_q == WAKE_BOOT);
    assign run_mask[h]  = (state_q == WAKE_RUN);

    // Boot is a single pulse followed by running
    a_boot_pulse: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
        boot_o.hart_mask[h] |=> (!boot_o.hart_mask[h] && running_o[h]))
      else $error("hart %0d boot pulse not followed by run", h);

    a_boot_not_running: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
        !(boot_o.hart_mask[h] && running_o[h]))
      else $error("hart %0d boots while running", h);
  end

  assign boot_o.hart_mask = boot_mask;
  // Entry is zero whenever no hart boots
  assign boot_o.entry     = (|boot_mask) ? entry_point_i : '0;
  assign running_o        = run_mask;

endmodule

// ==== hw/cluster_periph_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unmapped offsets read as zero and ignore writes
// Only the low CL_NR_HARTS bits of CLINT writes are used
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cluster_consts.svh"

module cluster_periph_regs
  import cluster_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  narrow_req_t  narrow_req_i,
  output narrow_resp_t narrow_resp_o,
  input  hart_mask_t   hart_running_i,
  output hart_mask_t   clint_pending_o,
  output addr_t        entry_point_o
);

  addr_t      scratch_q;
  hart_mask_t pending_q;
  hart_mask_t pending_d;
  hart_mask_t wr_mask;
  logic       sel_scratch;
  logic       sel_set;
  logic       sel_clr;
  logic       sel_status;
  logic       wr_en;
  logic       rd_en;
  data_t      rd_data;
  logic       resp_valid_q;
  data_t      resp_rdata_q;

  // Full-width compare so aliases above the map stay unmapped
  assign sel_scratch = (narrow_req_i.addr == addr_t'(`CL_REG_SCRATCH0));
  assign sel_set     = (narrow_req_i.addr == addr_t'(`CL_REG_CLINT_SET));
  assign sel_clr     = (narrow_req_i.addr == addr_t'(`CL_REG_CLINT_CLR));
  assign sel_status  = (narrow_req_i.addr == addr_t'(`CL_REG_STATUS));

  assign wr_en   = narrow_req_i.valid & narrow_req_i.write;
  assign rd_en   = narrow_req_i.valid & ~narrow_req_i.write;
  assign wr_mask = narrow_req_i.wdata[`CL_NR_HARTS-1:0];

  // Set and clear live at different offsets, so they never collide
  always_comb begin
    pending_d = pending_q;
    if (wr_en && sel_set) begin
      pending_d = pending_q | wr_mask;
    end else if (wr_en && sel_clr) begin
      pending_d = pending_q & ~wr_mask;
    end
  end

  always_comb begin
    rd_data = '0;
    if (sel_scratch) begin
      rd_data = data_t'(scratch_q);
    end else if (sel_set || sel_clr) begin
      rd_data = data_t'(pending_q);
    end else if (sel_status) begin
      // Pending above running, zero-extended
      rd_data = data_t'({pending_q, hart_running_i});
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q    <= '0;
      pending_q    <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      if (wr_en && sel_scratch) begin
        scratch_q <= addr_t'(narrow_req_i.wdata);
      end
      pending_q    <= pending_d;
      resp_valid_q <= narrow_req_i.valid;
    end
  end

  // Write responses and idle cycles carry zero data
  always_ff @(posedge clk_i) begin
    resp_rdata_q <= rd_en ? rd_data : '0;
  end

  assign narrow_resp_o.valid = resp_valid_q;
  assign narrow_resp_o.rdata = resp_rdata_q;

  assign clint_pending_o = pending_q;
  assign entry_point_o   = scratch_q;

  // Every request gets its response on the next cycle, and only then
  property p_resp_follows_req;
    @(posedge clk_i) disable iff (!arst_n_i)
      narrow_req_i.valid |=> narrow_resp_o.valid;
  endproperty

  property p_no_spurious_resp;
    @(posedge clk_i) disable iff (!arst_n_i)
      !narrow_req_i.valid |=> !narrow_resp_o.valid;
  endproperty

  // A pending mask read never shows bits beyond the hart count
  property p_pending_width;
    @(posedge clk_i) disable iff (!arst_n_i)
      (rd_en && (sel_set || sel_clr)) |=>
        (narrow_resp_o.rdata[`CL_DATA_W-1:`CL_NR_HARTS] == '0);
  endproperty

  a_resp_follows_req: assert property (p_resp_follows_req)
    else $error("no response one cycle after request");

  a_no_spurious_resp: assert property (p_no_spurious_resp)
    else $error("response without a request");

  a_pending_width: assert property (p_pending_width)
    else $error("pending read has bits above the hart count");

endmodule

// ==== hw/cluster_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths come from cluster_consts.svh
// The narrow bus has no ready, responses follow one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cluster_consts.svh"

package cluster_pkg;

  // Register offset or boot address
  typedef logic [`CL_DATA_W-1:0] addr_t;

  // Bus data word
  typedef logic [`CL_DATA_W-1:0] data_t;

  // One bit per hart
  typedef logic [`CL_NR_HARTS-1:0] hart_mask_t;

  // Narrow bus request, one access per valid cycle
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } narrow_req_t;

  // Narrow bus response, rdata is zero for writes
  typedef struct packed {
    logic  valid;
    data_t rdata;
  } narrow_resp_t;

  // Harts booting this cycle share one entry point
  typedef struct packed {
    hart_mask_t hart_mask;
    addr_t      entry;
  } boot_req_t;

  typedef enum logic [1:0] {
    WAKE_SLEEP = 2'd0,
    WAKE_BOOT  = 2'd1,
    WAKE_RUN   = 2'd2
  } wake_state_e;

endpackage

// ==== include/cluster_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The cluster size is fixed at build time
// Register offsets are byte offsets of 32-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CLUSTER_CONSTS_SVH
`define CLUSTER_CONSTS_SVH

// Number of harts in the cluster
`define CL_NR_HARTS 4

// Narrow bus data and address width
`define CL_DATA_W 32

// Peripheral register map
`define CL_REG_SCRATCH0  32'h0000_0000
`define CL_REG_CLINT_SET 32'h0000_0004
`define CL_REG_CLINT_CLR 32'h0000_0008
`define CL_REG_STATUS    32'h0000_000C

`endif
